// ==== blit_vectors.txt ====
# blitter commands, all fields in hex
# opcode flash_start flash_end sram_dest
00 000000 000000 00100
01 000010 00001f 00200
01 000020 000024 00300
01 000040 000040 00400
07 000000 000010 00500
01 000003 000003 00480
01 0000fe 000103 ffffe
00 000000 000000 ffff0
ff 000011 000012 00600
01 7ffff0 7fffff 00700
01 000100 000132 01000
02 000000 000004 00900
01 000055 000058 02000
00 000000 000000 03000

// ==== verilog.f ====
+incdir+.
blit_pkg.sv
blit_sequencer.sv
flash_reader.sv
pixel_packer.sv
sram_writer.sv
blitter.sv
blitter_checker.sv
blitter_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the blitter testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module blitter_tb -f verilog.f -o blitter_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/blitter_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
  exit 0
fi
exit 1

// ==== blitter_tb.sv ====
`default_nettype none

`include "blit_settings.svh"

module blitter_tb;

  localparam int max_cmds = 32;

  logic                  clk;
  logic                  reset;
  blit_pkg::opcode_t     op_code;
  blit_pkg::flash_addr_t start_address;
  blit_pkg::flash_addr_t end_address;
  blit_pkg::sram_addr_t  dest_address;
  logic                  draw_en;
  logic                  draw_complete;
  blit_pkg::flash_byte_t fl_dq;
  blit_pkg::flash_addr_t fl_addr;
  logic                  fl_ce_n;
  logic                  fl_oe_n;
  logic                  fl_we_n;
  logic                  fl_rst_n;
  logic                  fl_wp_n;
  blit_pkg::sram_addr_t  sram_addr;
  blit_pkg::pixel_word_t sram_dq;
  logic                  sram_we_n;
  logic                  sram_ce_n;
  logic                  sram_ub_n;
  logic                  sram_lb_n;
  logic                  sram_oe_n;

  blit_pkg::opcode_t     vec_op[max_cmds];
  blit_pkg::flash_addr_t vec_start[max_cmds];
  blit_pkg::flash_addr_t vec_end[max_cmds];
  blit_pkg::sram_addr_t  vec_dest[max_cmds];
  int                    num_cmds;
  blit_pkg::sram_addr_t  exp_addr_q[$];  // predicted writes, oldest first.
  blit_pkg::pixel_word_t exp_word_q[$];
  blit_pkg::flash_addr_t exp_fl_addr;    // flash byte the next read must ask for.
  logic                  fl_ce_q;
  int                    addr_errors;
  int                    data_errors;
  int                    flash_errors;
  int                    other_errors;
  int                    cycle_count;
  int                    cycle_limit;
  logic [16:0]           lfsr;
  logic                  started;        // the first draw_en has gone out.

  blitter i_blitter (
    .clk           (clk),
    .reset         (reset),
    .op_code       (op_code),
    .start_address (start_address),
    .end_address   (end_address),
    .dest_address  (dest_address),
    .draw_en       (draw_en),
    .draw_complete (draw_complete),
    .fl_dq         (fl_dq),
    .fl_addr       (fl_addr),
    .fl_ce_n       (fl_ce_n),
    .fl_oe_n       (fl_oe_n),
    .fl_we_n       (fl_we_n),
    .fl_rst_n      (fl_rst_n),
    .fl_wp_n       (fl_wp_n),
    .sram_addr     (sram_addr),
    .sram_dq       (sram_dq),
    .sram_we_n     (sram_we_n),
    .sram_ce_n     (sram_ce_n),
    .sram_ub_n     (sram_ub_n),
    .sram_lb_n     (sram_lb_n),
    .sram_oe_n     (sram_oe_n)
  );

  // flash model, content is a pattern of the address.
  assign fl_dq = (!fl_ce_n && !fl_oe_n) ? (fl_addr[7:0] ^ 8'ha5) : 8'h00;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};  // x^17 + x^14 + 1.
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
  endtask

  function automatic blit_pkg::flash_byte_t flash_byte(input blit_pkg::flash_addr_t a);
    return a[7:0] ^ 8'ha5;
  endfunction

  task automatic check_addr(input blit_pkg::sram_addr_t got, input blit_pkg::sram_addr_t exp);
    if (got !== exp) begin
      $display("Error: sram_addr is %h, expected %h", got, exp);
      addr_errors++;
    end
  endtask

  task automatic check_word(input blit_pkg::pixel_word_t got, input blit_pkg::pixel_word_t exp);
    if (got !== exp) begin
      $display("Error: sram_dq is %h, expected %h", got, exp);
      data_errors++;
    end
  endtask

  task automatic check_flash_addr(input blit_pkg::flash_addr_t got,
                                  input blit_pkg::flash_addr_t exp);
    if (got !== exp) begin
      $display("Error: fl_addr is %h, expected %h", got, exp);
      flash_errors++;
    end
  endtask

  // queue up every write a command should produce.
  task automatic predict(input int idx);
    blit_pkg::flash_addr_t a;
    blit_pkg::sram_addr_t  d;
    blit_pkg::flash_byte_t hi;
    blit_pkg::flash_byte_t lo;
    int                    n;
    d = vec_dest[idx];
    a = vec_start[idx];
    n = int'(vec_end[idx]) - int'(vec_start[idx]) + 1;
    if (vec_op[idx] == `BLIT_OP_CLEAR) begin
      for (int k = 0; k < `BLIT_CLEAR_WORDS; k++) begin
        exp_addr_q.push_back(d);
        exp_word_q.push_back(16'h0000);
        d = d + 1'b1;
      end
    end else if (vec_op[idx] == `BLIT_OP_COPY) begin
      exp_fl_addr = vec_start[idx];
      for (int k = 0; k < n; k += 2) begin
        hi = flash_byte(a);
        a = a + 1'b1;
        lo = (k + 1 < n) ? flash_byte(a) : 8'h00;  // odd tail is padded.
        a = a + 1'b1;
        exp_addr_q.push_back(d);
        exp_word_q.push_back({hi, lo});
        d = d + 1'b1;
      end
    end
  endtask

  task automatic run_command(input int idx);
    logic [7:0] r;
    logic       done;
    predict(idx);
    @(negedge clk);
    op_code       = vec_op[idx];
    start_address = vec_start[idx];
    end_address   = vec_end[idx];
    dest_address  = vec_dest[idx];
    draw_en       = 1'b1;
    started       = 1'b1;
    @(negedge clk);
    draw_en = 1'b0;
    if (vec_op[idx] != `BLIT_OP_CLEAR && vec_op[idx] != `BLIT_OP_COPY) begin
      repeat (20) begin
        @(negedge clk);
        if (draw_complete) begin
          $display("draw_complete pulsed for ignored opcode %h", vec_op[idx]);
          other_errors++;
        end
      end
    end else begin
      done = 1'b0;
      while (!done) begin
        // stray requests while busy, with scrambled command fields.
        take_bits(2, r);
        draw_en = (r[1:0] == 2'b11);
        take_bits(8, r);
        op_code      = `BLIT_OP_COPY;
        dest_address = blit_pkg::sram_addr_t'(r);
        @(negedge clk);
        done = draw_complete;
      end
      draw_en = 1'b0;
      if (exp_addr_q.size() != 0) begin
        $display("command %0d finished with %0d writes missing", idx, exp_addr_q.size());
        other_errors++;
        exp_addr_q.delete();
        exp_word_q.delete();
      end
    end
  endtask

  // write monitor, sampled in the middle of the cycle.
  always @(negedge clk) begin
    if (reset) begin
      if (!sram_we_n) begin
        if (exp_addr_q.size() == 0) begin
          $display("unexpected SRAM write to address %h", sram_addr);
          other_errors++;
        end else begin
          check_addr(sram_addr, exp_addr_q.pop_front());
          check_word(sram_dq, exp_word_q.pop_front());
        end
      end
      if (sram_ce_n !== sram_we_n || sram_ub_n !== sram_we_n || sram_lb_n !== sram_we_n) begin
        $display("SRAM chip or byte enables do not follow the write strobe");
        other_errors++;
      end
      if (!fl_ce_n && !started) begin
        $display("flash read before the first command");
        other_errors++;
      end
      if (!fl_ce_n && fl_ce_q) begin  // first cycle of a flash read.
        check_flash_addr(fl_addr, exp_fl_addr);
        exp_fl_addr = exp_fl_addr + 1'b1;
      end
      if (!fl_we_n || !fl_rst_n || !fl_wp_n || !sram_oe_n) begin
        $display("a pin that must stay high went low");
        other_errors++;
      end
    end
    fl_ce_q = fl_ce_n;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("run stopped after %0d cycles without finishing", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    int          fd;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_start;
    logic [31:0] f_end;
    logic [31:0] f_dest;
    logic [7:0]  gap;
    reset         = 1'b0;
    draw_en       = 1'b0;
    op_code       = '0;
    start_address = '0;
    end_address   = '0;
    dest_address  = '0;
    started       = 1'b0;
    exp_fl_addr   = '0;
    lfsr          = 17'd80606;
    num_cmds      = 0;
    addr_errors   = 0;
    data_errors   = 0;
    flash_errors  = 0;
    other_errors  = 0;
    cycle_count   = 0;
    cycle_limit   = 40;  // reset and quiet period.
    fd = $fopen("blit_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open blit_vectors.txt");
      $display("STATUS: FAIL");
      $finish;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%h %h %h %h", f_op, f_start, f_end, f_dest) == 4
            && num_cmds < max_cmds) begin
          vec_op[num_cmds]    = f_op[7:0];
          vec_start[num_cmds] = f_start[22:0];
          vec_end[num_cmds]   = f_end[22:0];
          vec_dest[num_cmds]  = f_dest[19:0];
          num_cmds++;
        end
      end
      $fclose(fd);
      for (int i = 0; i < num_cmds; i++) begin
        if (vec_op[i] == `BLIT_OP_COPY) begin
          cycle_limit += (int'(vec_end[i]) - int'(vec_start[i]) + 1) * (`BLIT_FLASH_WAIT + 2);
        end
        cycle_limit += `BLIT_CLEAR_WORDS + 30;
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b1;
      repeat (10) @(negedge clk);  // nothing may move yet.
      for (int i = 0; i < num_cmds; i++) begin
        run_command(i);
        take_bits(4, gap);
        repeat (gap[3:0]) @(negedge clk);
      end
      $display("errors: address %0d, data %0d, flash %0d, other %0d",
               addr_errors, data_errors, flash_errors, other_errors);
      if (addr_errors + data_errors + flash_errors + other_errors == 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== blitter_checker.sv ====
`default_nettype none

module blitter_checker (
  input logic                 clk,
  input logic                 reset,
  input logic                 strobe_n,     // write strobe, low once per word.
  input blit_pkg::sram_addr_t strobe_addr,
  input logic                 pulse,        // must never be wider than one cycle.
  input logic                 select_n,
  input logic                 enable_n      // only allowed low while select_n is low.
);

  // back to back strobes mean back to back words.
  write_per_word: assert property (@(posedge clk) disable iff (!reset)
    (!strobe_n && !$past(strobe_n)) |-> (strobe_addr == $past(strobe_addr) + 1'b1))
    else $error("write strobe held over two cycles for the same word");

  pulse_width: assert property (@(posedge clk) disable iff (!reset)
    pulse |=> !pulse)
    else $error("pulse wider than one cycle");

  enable_in_select: assert property (@(posedge clk) disable iff (!reset)
    !enable_n |-> !select_n)
    else $error("output enable low without chip enable");

endmodule

// the sram strobes share one net, so the enable pair is tied off.
bind sram_writer blitter_checker i_write_checker (
  .clk         (clk),
  .reset       (reset),
  .strobe_n    (sram_we_n),
  .strobe_addr (sram_addr),
  .pulse       (draw_complete),
  .select_n    (1'b1),
  .enable_n    (1'b1)
);

// the flash side has no write strobe.
bind flash_reader blitter_checker i_read_checker (
  .clk         (clk),
  .reset       (reset),
  .strobe_n    (1'b1),
  .strobe_addr ('0),
  .pulse       (byte_valid),
  .select_n    (fl_ce_n),
  .enable_n    (fl_oe_n)
);

`default_nettype wire

// ==== blitter.sv ====
`default_nettype none

module blitter (
  input  logic                  clk,
  input  logic                  reset,
  // host side.
  input  blit_pkg::opcode_t     op_code,
  input  blit_pkg::flash_addr_t start_address,
  input  blit_pkg::flash_addr_t end_address,
  input  blit_pkg::sram_addr_t  dest_address,
  input  logic                  draw_en,
  output logic                  draw_complete,
  // NOR flash.
  input  blit_pkg::flash_byte_t fl_dq,
  output blit_pkg::flash_addr_t fl_addr,
  output logic                  fl_ce_n,
  output logic                  fl_oe_n,
  output logic                  fl_we_n,
  output logic                  fl_rst_n,
  output logic                  fl_wp_n,
  // frame buffer SRAM.
  output blit_pkg::sram_addr_t  sram_addr,
  output blit_pkg::pixel_word_t sram_dq,
  output logic                  sram_we_n,
  output logic                  sram_ce_n,
  output logic                  sram_ub_n,
  output logic                  sram_lb_n,
  output logic                  sram_oe_n
);

  logic                  read_req;
  blit_pkg::flash_addr_t read_addr;
  logic                  byte_valid;
  blit_pkg::flash_byte_t byte_data;
  logic                  byte_last;
  logic                  byte_first_half;
  logic                  clear_word;
  logic                  clear_last;
  logic                  start_pulse;
  blit_pkg::sram_addr_t  dest_addr;
  logic                  word_valid;
  blit_pkg::pixel_word_t word_data;
  logic                  word_last;

  assign fl_wp_n = 1'b1;  // flash is never programmed.

  blit_sequencer i_sequencer (
    .clk             (clk),
    .reset           (reset),
    .draw_en         (draw_en),
    .op_code         (op_code),
    .start_address   (start_address),
    .end_address     (end_address),
    .dest_address    (dest_address),
    .byte_valid      (byte_valid),
    .read_req        (read_req),
    .read_addr       (read_addr),
    .byte_last       (byte_last),
    .byte_first_half (byte_first_half),
    .clear_word      (clear_word),
    .clear_last      (clear_last),
    .start_pulse     (start_pulse),
    .dest_addr       (dest_addr)
  );

  flash_reader i_flash_reader (
    .clk        (clk),
    .reset      (reset),
    .read_req   (read_req),
    .read_addr  (read_addr),
    .fl_dq      (fl_dq),
    .fl_addr    (fl_addr),
    .fl_ce_n    (fl_ce_n),
    .fl_oe_n    (fl_oe_n),
    .fl_we_n    (fl_we_n),
    .fl_rst_n   (fl_rst_n),
    .byte_valid (byte_valid),
    .byte_data  (byte_data)
  );

  pixel_packer i_pixel_packer (
    .clk             (clk),
    .reset           (reset),
    .byte_valid      (byte_valid),
    .byte_data       (byte_data),
    .byte_last       (byte_last),
    .byte_first_half (byte_first_half),
    .clear_word      (clear_word),
    .clear_last      (clear_last),
    .word_valid      (word_valid),
    .word_data       (word_data),
    .word_last       (word_last)
  );

  sram_writer i_sram_writer (
    .clk           (clk),
    .reset         (reset),
    .start_pulse   (start_pulse),
    .dest_addr     (dest_addr),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .word_last     (word_last),
    .sram_addr     (sram_addr),
    .sram_dq       (sram_dq),
    .sram_we_n     (sram_we_n),
    .sram_ce_n     (sram_ce_n),
    .sram_ub_n     (sram_ub_n),
    .sram_lb_n     (sram_lb_n),
    .sram_oe_n     (sram_oe_n),
    .draw_complete (draw_complete)
  );

endmodule

`default_nettype wire

// ==== sram_writer.sv ====
`default_nettype none

module sram_writer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start_pulse,
  input  blit_pkg::sram_addr_t  dest_addr,
  input  logic                  word_valid,
  input  blit_pkg::pixel_word_t word_data,
  input  logic                  word_last,
  output blit_pkg::sram_addr_t  sram_addr,
  output blit_pkg::pixel_word_t sram_dq,
  output logic                  sram_we_n,
  output logic                  sram_ce_n,
  output logic                  sram_ub_n,
  output logic                  sram_lb_n,
  output logic                  sram_oe_n,
  output logic                  draw_complete
);

  blit_pkg::sram_addr_t addr_cnt;  // next word address.
  logic                 write_n;   // shared strobe, low during the write cycle.
  logic                 last_q;    // the word being written closes the command.

  // both byte lanes are written every time.
  assign sram_we_n = write_n;
  assign sram_ce_n = write_n;
  assign sram_ub_n = write_n;
  assign sram_lb_n = write_n;
  assign sram_oe_n = 1'b1;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      addr_cnt      <= '0;
      write_n       <= 1'b1;
      last_q        <= 1'b0;
      draw_complete <= 1'b0;
    end else begin
      write_n       <= !word_valid;
      draw_complete <= !write_n && last_q;
      if (start_pulse) begin
        addr_cnt <= dest_addr;
      end else if (word_valid) begin
        addr_cnt <= addr_cnt + 1'b1;
      end
      if (word_valid) last_q <= word_last;
    end
  end

  always_ff @(posedge clk) begin
    if (word_valid) begin
      sram_addr <= addr_cnt;
      sram_dq   <= word_data;
    end
  end

endmodule

`default_nettype wire

// ==== pixel_packer.sv ====
`default_nettype none

module pixel_packer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  byte_valid,
  input  blit_pkg::flash_byte_t byte_data,
  input  logic                  byte_last,
  input  logic                  byte_first_half,
  input  logic                  clear_word,
  input  logic                  clear_last,
  output logic                  word_valid,
  output blit_pkg::pixel_word_t word_data,
  output logic                  word_last
);

  blit_pkg::flash_byte_t high_byte;
  logic                  have_high;   // a first byte is waiting for its partner.
  logic                  pair_start;

  assign pair_start = byte_first_half || !have_high;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      word_valid <= 1'b0;
      have_high  <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (clear_word) begin
        word_valid <= 1'b1;
      end else if (byte_valid) begin
        if (pair_start) begin
          have_high  <= !byte_last;
          word_valid <= byte_last;  // odd tail goes out padded.
        end else begin
          have_high  <= 1'b0;
          word_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clear_word) begin
      word_data <= '0;  // black.
      word_last <= clear_last;
    end else if (byte_valid) begin
      word_last <= byte_last;
      if (pair_start) begin
        high_byte <= byte_data;
        word_data <= {byte_data, 8'h00};
      end else begin
        word_data <= {high_byte, byte_data};
      end
    end
  end

endmodule

`default_nettype wire

// ==== flash_reader.sv ====
`default_nettype none

`include "blit_settings.svh"

module flash_reader (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  read_req,
  input  blit_pkg::flash_addr_t read_addr,
  input  blit_pkg::flash_byte_t fl_dq,
  output blit_pkg::flash_addr_t fl_addr,
  output logic                  fl_ce_n,
  output logic                  fl_oe_n,
  output logic                  fl_we_n,
  output logic                  fl_rst_n,
  output logic                  byte_valid,
  output blit_pkg::flash_byte_t byte_data
);

  logic [7:0] wait_cnt;  // cycles spent with fl_oe_n low.
  logic       last_wait;

  assign fl_we_n  = 1'b1;  // read only.
  assign fl_rst_n = 1'b1;

  assign last_wait = (wait_cnt == 8'(`BLIT_FLASH_WAIT - 1));

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      fl_ce_n    <= 1'b1;
      fl_oe_n    <= 1'b1;
      byte_valid <= 1'b0;
      wait_cnt   <= '0;
    end else begin
      byte_valid <= 1'b0;
      if (!fl_ce_n) begin
        wait_cnt <= wait_cnt + 1'b1;
        if (last_wait) begin
          fl_ce_n    <= 1'b1;
          fl_oe_n    <= 1'b1;
          byte_valid <= 1'b1;
        end
      end else if (read_req) begin
        fl_ce_n  <= 1'b0;  // chip and output enabled together.
        fl_oe_n  <= 1'b0;
        wait_cnt <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fl_ce_n && read_req) fl_addr <= read_addr;
    if (!fl_ce_n && last_wait) byte_data <= fl_dq;  // access time has passed.
  end

endmodule

`default_nettype wire

// ==== blit_sequencer.sv ====
`default_nettype none

`include "blit_settings.svh"

module blit_sequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  draw_en,
  input  blit_pkg::opcode_t     op_code,
  input  blit_pkg::flash_addr_t start_address,
  input  blit_pkg::flash_addr_t end_address,
  input  blit_pkg::sram_addr_t  dest_address,
  input  logic                  byte_valid,
  output logic                  read_req,
  output blit_pkg::flash_addr_t read_addr,
  output logic                  byte_last,
  output logic                  byte_first_half,
  output logic                  clear_word,
  output logic                  clear_last,
  output logic                  start_pulse,
  output blit_pkg::sram_addr_t  dest_addr
);

  blit_pkg::seq_state_t  state;
  blit_pkg::flash_addr_t end_addr_q;  // inclusive end of the copy range.
  blit_pkg::flash_addr_t next_addr;
  logic [15:0]           count;       // clear words, then drain cycles.
  logic                  accept;
  logic                  step;

  assign accept = (state == blit_pkg::idle) && draw_en;
  assign next_addr = blit_pkg::flash_addr_t'(read_addr + 1'b1);
  // a byte came back and more remain in the range.
  assign step = (state == blit_pkg::wait_byte) && (count == 16'd0) && byte_valid && !byte_last;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state       <= blit_pkg::idle;
      start_pulse <= 1'b0;
      read_req    <= 1'b0;
      clear_word  <= 1'b0;
      count       <= '0;
    end else begin
      start_pulse <= 1'b0;
      read_req    <= 1'b0;
      clear_word  <= 1'b0;
      case (state)
        blit_pkg::idle: begin
          if (draw_en) begin
            if (op_code == `BLIT_OP_CLEAR) begin
              state       <= blit_pkg::clear;
              start_pulse <= 1'b1;
              count       <= '0;
            end else if (op_code == `BLIT_OP_COPY) begin
              state       <= blit_pkg::fetch;
              start_pulse <= 1'b1;
            end  // anything else is dropped.
          end
        end
        blit_pkg::clear: begin
          count <= count + 1'b1;
          if (count < 16'(`BLIT_CLEAR_WORDS)) clear_word <= 1'b1;
          // three extra cycles cover the packer and writer.
          if (count == 16'(`BLIT_CLEAR_WORDS + 2)) state <= blit_pkg::idle;
        end
        blit_pkg::fetch: begin
          read_req <= 1'b1;  // first byte of the copy.
          count    <= '0;
          state    <= blit_pkg::wait_byte;
        end
        blit_pkg::wait_byte: begin
          if (count != 16'd0) begin
            // draining after the last byte.
            count <= count + 1'b1;
            if (count == 16'd2) state <= blit_pkg::idle;
          end else if (byte_valid) begin
            if (byte_last) count <= 16'd1;
            else read_req <= 1'b1;
          end
        end
        default: state <= blit_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      read_addr  <= start_address;
      end_addr_q <= end_address;
      dest_addr  <= dest_address;
    end
    if (state == blit_pkg::clear) clear_last <= (count == 16'(`BLIT_CLEAR_WORDS - 1));
    if (state == blit_pkg::fetch) begin
      byte_last       <= (read_addr >= end_addr_q);  // a reversed range reads one byte.
      byte_first_half <= 1'b1;
    end
    if (step) begin
      read_addr       <= next_addr;
      byte_last       <= (next_addr >= end_addr_q);
      byte_first_half <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== blit_pkg.sv ====
`default_nettype none

package blit_pkg;

  typedef logic [22:0] flash_addr_t;  // byte address into the NOR flash.
  typedef logic [7:0] flash_byte_t;
  typedef logic [19:0] sram_addr_t;   // word address into the frame buffer.
  typedef logic [15:0] pixel_word_t;
  typedef logic [7:0] opcode_t;

  // sequencer states.
  typedef enum logic [1:0] {
    idle,
    clear,
    fetch,
    wait_byte
  } seq_state_t;

endpackage

`default_nettype wire

// ==== blit_settings.svh ====
`ifndef BLIT_SETTINGS_SVH
`define BLIT_SETTINGS_SVH

// cycles fl_oe_n stays low before the data byte is taken.
`define BLIT_FLASH_WAIT 4

// number of black words written by one clear.
`define BLIT_CLEAR_WORDS 64

// host command codes.
`define BLIT_OP_CLEAR 8'h00
`define BLIT_OP_COPY 8'h01

`endif
